// ==== hw/ntt_addr_pkg.sv ====
// ring and PE geometry, pipeline latencies and the bank address word
// shared by the NTT address sequencer and its testbench model
`default_nettype none

package ntt_addr_pkg;

    // ------------------------------------------------------------------------
    // geometry
    localparam int RING_DEPTH   = 8;                            // log2 ring size
    localparam int PE_DEPTH     = 2;                            // log2 PE count
    localparam int RING_SIZE    = 1 << RING_DEPTH;              // 256 coefficients
    localparam int STAGES       = RING_DEPTH;                   // one stage per bit
    localparam int LOOPS        = RING_SIZE >> (PE_DEPTH + 1);  // N / (2*PE) = 32
    localparam int ROW_W        = RING_DEPTH - PE_DEPTH;        // bank row width
    localparam int LOOP_W       = ROW_W;
    localparam int STAGE_W      = 4;
    localparam int BANK_W       = 2;                            // bank-half bits
    localparam int ADDR_W       = BANK_W + ROW_W;
    localparam int SPLIT_STAGES = ROW_W - 1;                    // stages with split rows

    // ------------------------------------------------------------------------
    // latencies
    localparam int WAIT_CYCLES     = 16;                        // drain between stages
    localparam int WAIT_W          = $clog2(WAIT_CYCLES);
    localparam int MUL_DELAY       = 4;                         // integer multiplier
    localparam int RED_DELAY       = 4;                         // modular reduction
    localparam int STAGE_DELAY     = 2;                         // add/sub and output regs
    localparam int BUTTERFLY_DELAY = MUL_DELAY + RED_DELAY + STAGE_DELAY;
    localparam int DONE_DELAY      = 4;

    // sequencer state codes
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;

    // write bank bits, loaded on start and forced before the last stage
    localparam logic [BANK_W-1:0] WR_BANK_INIT = 2'b01;
    localparam logic [BANK_W-1:0] WR_BANK_LAST = 2'b10;

    // memory address: flat word for the RAM port, or bank half plus row
    typedef union packed {
        logic [ADDR_W-1:0] word;
        struct packed {
            logic [BANK_W-1:0] bank;
            logic [ROW_W-1:0]  row;
        } f;
    } bank_addr_t;

endpackage

`default_nettype wire

// ==== hw/delay_line.sv ====
// fixed-depth register chain, used to line signals up with the
// butterfly and done latencies
`default_nettype none
`timescale 1ns/1ps

module delay_line #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    logic [WIDTH-1:0] taps [DEPTH];    // taps[0] is the first register

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                taps[i] <= '0;
            end
        end else begin
            taps[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                taps[i] <= taps[i-1];    // shift one step per clock
            end
        end
    end

    assign q = taps[DEPTH-1];

    // a zero-depth chain would leave q without a driver
    initial assert (DEPTH >= 1) else $error("delay_line needs DEPTH >= 1");

endmodule

`default_nettype wire

// ==== hw/ntt_sequencer.sv ====
// stage/loop sequencer of the NTT engine: on start it runs all butterfly
// stages, each as LOOPS issue cycles and WAIT_CYCLES drain cycles
`default_nettype none
`timescale 1ns/1ps

module ntt_sequencer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    output logic                             run,
    output logic                             stage_end,
    output logic                             done,
    output logic [ntt_addr_pkg::LOOP_W-1:0]  loop_idx,
    output logic [ntt_addr_pkg::STAGE_W-1:0] stage_idx
);

    logic [1:0]                      state;
    logic [ntt_addr_pkg::WAIT_W-1:0] wait_cnt;     // drain cycle counter
    logic                            in_wait;
    logic                            loop_last;
    logic                            stage_last;

    assign run        = (state == ntt_addr_pkg::ST_RUN);
    assign in_wait    = (state == ntt_addr_pkg::ST_WAIT);
    assign loop_last  = (loop_idx == ntt_addr_pkg::LOOP_W'(ntt_addr_pkg::LOOPS - 1));
    assign stage_last = (stage_idx == ntt_addr_pkg::STAGE_W'(ntt_addr_pkg::STAGES - 1));

    // last drain cycle of the current stage
    assign stage_end = in_wait &&
                       (wait_cnt == ntt_addr_pkg::WAIT_W'(ntt_addr_pkg::WAIT_CYCLES - 1));

    // ------------------------------------------------------------------------
    // FSM and counters
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ntt_addr_pkg::ST_IDLE;
            loop_idx  <= '0;
            stage_idx <= '0;
            wait_cnt  <= '0;
            done      <= 1'b0;
        end else begin
            done <= stage_end && stage_last;    // one cycle after the final drain
            case (state)
                ntt_addr_pkg::ST_IDLE: begin
                    if (start) begin            // only sampled here, ignored mid-run
                        state <= ntt_addr_pkg::ST_RUN;
                    end
                end
                ntt_addr_pkg::ST_RUN: begin
                    if (loop_last) begin
                        loop_idx <= '0;
                        state    <= ntt_addr_pkg::ST_WAIT;
                    end else begin
                        loop_idx <= loop_idx + 1'b1;
                    end
                end
                ntt_addr_pkg::ST_WAIT: begin
                    if (stage_end) begin
                        wait_cnt <= '0;
                        if (stage_last) begin
                            stage_idx <= '0;     // whole transform done
                            state     <= ntt_addr_pkg::ST_IDLE;
                        end else begin
                            stage_idx <= stage_idx + 1'b1;
                            state     <= ntt_addr_pkg::ST_RUN;
                        end
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ntt_addr_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // loop counter rests at 0 outside the issue cycles
    a_loop_idle: assert property (@(posedge clk) disable iff (reset)
        !run |-> loop_idx == '0);

    a_stage_range: assert property (@(posedge clk) disable iff (reset)
        stage_idx < ntt_addr_pkg::STAGE_W'(ntt_addr_pkg::STAGES));

endmodule

`default_nettype wire

// ==== hw/ntt_addr_calc.sv ====
// address stage: turns stage and loop index into the read row, the even
// and odd write rows, the bank-half bits and the write strobes
// all outputs are registered one cycle after the sequencer
`default_nettype none
`timescale 1ns/1ps

module ntt_addr_calc (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    input  logic                             run,
    input  logic                             stage_end,
    input  logic [ntt_addr_pkg::LOOP_W-1:0]  loop_idx,
    input  logic [ntt_addr_pkg::STAGE_W-1:0] stage_idx,
    output ntt_addr_pkg::bank_addr_t         rd_addr,
    output ntt_addr_pkg::bank_addr_t         wr_addr_even,
    output ntt_addr_pkg::bank_addr_t         wr_addr_odd,
    output logic                             wen,
    output logic                             brsel,
    output logic                             brselen,
    output logic [ntt_addr_pkg::STAGE_W-1:0] stage_q
);

    logic [ntt_addr_pkg::STAGE_W-1:0] span_sh;    // log2 of the row span
    logic [ntt_addr_pkg::ROW_W-1:0]   span;
    logic [ntt_addr_pkg::ROW_W-1:0]   base_row;
    logic [ntt_addr_pkg::ROW_W-1:0]   hi_row;     // base plus span
    logic                             split;
    logic                             active;     // a transform is in progress
    logic [ntt_addr_pkg::BANK_W-1:0]  rd_bank;
    logic [ntt_addr_pkg::BANK_W-1:0]  wr_bank;
    logic [ntt_addr_pkg::ROW_W-1:0]   rd_row;
    logic [ntt_addr_pkg::ROW_W-1:0]   even_row;
    logic [ntt_addr_pkg::ROW_W-1:0]   odd_row;

    // ------------------------------------------------------------------------
    // row arithmetic
    // span halves every stage: 16, 8, 4, 2, 1 for stages 0..4
    assign split    = stage_idx < ntt_addr_pkg::STAGE_W'(ntt_addr_pkg::SPLIT_STAGES);
    assign span_sh  = ntt_addr_pkg::STAGE_W'(ntt_addr_pkg::SPLIT_STAGES - 1) - stage_idx;
    assign span     = ntt_addr_pkg::ROW_W'(1) << span_sh;
    // l/2 plus the block offset l/(2*span)*span
    assign base_row = (loop_idx >> 1) + ((loop_idx >> (span_sh + 1'b1)) << span_sh);
    assign hi_row   = base_row + span;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_row   <= '0;
            even_row <= '0;
            odd_row  <= '0;
        end else if (run) begin
            if (split) begin
                rd_row   <= loop_idx[0] ? hi_row : base_row;   // 0,16,1,17.. in stage 0
                even_row <= base_row;
                odd_row  <= hi_row;
            end else begin
                rd_row   <= loop_idx;   // late stages pass rows straight through
                even_row <= loop_idx;
                odd_row  <= loop_idx;
            end
        end
    end

    // ------------------------------------------------------------------------
    // bank-half bits, ping-pong between stages
    always_ff @(posedge clk) begin
        if (reset) begin
            active  <= 1'b0;
            rd_bank <= '0;
            wr_bank <= '0;
        end else if (start && !active) begin
            active  <= 1'b1;
            rd_bank <= '0;
            wr_bank <= ntt_addr_pkg::WR_BANK_INIT;   // write into the other half
        end else if (stage_end) begin
            rd_bank[0] <= ~rd_bank[0];
            if (stage_idx == ntt_addr_pkg::STAGE_W'(ntt_addr_pkg::STAGES - 2)) begin
                wr_bank <= ntt_addr_pkg::WR_BANK_LAST;   // last stage result area
            end else begin
                wr_bank[0] <= ~wr_bank[0];
            end
            if (stage_idx == ntt_addr_pkg::STAGE_W'(ntt_addr_pkg::STAGES - 1)) begin
                active <= 1'b0;
            end
        end
    end

    // strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            wen     <= 1'b0;
            brsel   <= 1'b0;
            brselen <= 1'b0;
            stage_q <= '0;
        end else begin
            wen     <= run;
            brsel   <= run && loop_idx[0];   // even/odd BRAM alternates each issue
            brselen <= run;
            stage_q <= stage_idx;
        end
    end

    // pack bank bits and rows into the address words
    always_comb begin
        rd_addr.f.bank      = rd_bank;
        rd_addr.f.row       = rd_row;
        wr_addr_even.f.bank = wr_bank;
        wr_addr_even.f.row  = even_row;
        wr_addr_odd.f.bank  = wr_bank;
        wr_addr_odd.f.row   = odd_row;
    end

    // ------------------------------------------------------------------------
    // checks
    // a stage never writes into the half it reads from
    a_bank_halves: assert property (@(posedge clk) disable iff (reset)
        wen |-> (wr_addr_even.f.bank != rd_addr.f.bank));

    // bank bit tracking must agree with the sequencer's idle state
    a_run_active: assert property (@(posedge clk) disable iff (reset)
        run |-> active);

endmodule

`default_nettype wire

// ==== hw/ntt_write_align.sv ====
// alignment stage: one more register on the read address, butterfly
// latency on the write side (odd side one cycle later) and the done delay
`default_nettype none
`timescale 1ns/1ps

module ntt_write_align (
    input  logic                             clk,
    input  logic                             reset,
    input  ntt_addr_pkg::bank_addr_t         rd_addr,
    input  ntt_addr_pkg::bank_addr_t         wr_addr_even,
    input  ntt_addr_pkg::bank_addr_t         wr_addr_odd,
    input  logic                             wen,
    input  logic                             brsel,
    input  logic                             brselen,
    input  logic                             done,
    input  logic [ntt_addr_pkg::STAGE_W-1:0] stage_q,
    output ntt_addr_pkg::bank_addr_t         raddr0,
    output ntt_addr_pkg::bank_addr_t         waddr0,
    output ntt_addr_pkg::bank_addr_t         waddr1,
    output logic                             wen0,
    output logic                             wen1,
    output logic                             brsel0,
    output logic                             brsel1,
    output logic                             brselen0,
    output logic                             brselen1,
    output logic                             ntt_finished,
    output logic [ntt_addr_pkg::STAGE_W-1:0] stage_count
);

    // even side: address and three strobes
    logic [ntt_addr_pkg::ADDR_W+2:0]                      even_d;
    logic [ntt_addr_pkg::ADDR_W+2:0]                      even_q;
    // odd side carries the stage count as well
    logic [ntt_addr_pkg::ADDR_W+ntt_addr_pkg::STAGE_W+2:0] odd_d;
    logic [ntt_addr_pkg::ADDR_W+ntt_addr_pkg::STAGE_W+2:0] odd_q;

    // read side, second register after the sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            raddr0 <= '0;
        end else begin
            raddr0 <= rd_addr;
        end
    end

    // ------------------------------------------------------------------------
    // write side
    assign even_d = {wr_addr_even.word, wen, brsel, brselen};
    assign odd_d  = {wr_addr_odd.word, wen, brsel, brselen, stage_q};

    delay_line #(
        .DEPTH (ntt_addr_pkg::BUTTERFLY_DELAY),
        .WIDTH (ntt_addr_pkg::ADDR_W + 3)
    ) u_even_dly (
        .clk   (clk),
        .reset (reset),
        .d     (even_d),
        .q     (even_q)
    );

    delay_line #(
        .DEPTH (ntt_addr_pkg::BUTTERFLY_DELAY + 1),   // odd result leaves one cycle later
        .WIDTH (ntt_addr_pkg::ADDR_W + ntt_addr_pkg::STAGE_W + 3)
    ) u_odd_dly (
        .clk   (clk),
        .reset (reset),
        .d     (odd_d),
        .q     (odd_q)
    );

    assign {waddr0.word, wen0, brsel0, brselen0}              = even_q;
    assign {waddr1.word, wen1, brsel1, brselen1, stage_count} = odd_q;

    // finished pulse
    delay_line #(
        .DEPTH (ntt_addr_pkg::DONE_DELAY),
        .WIDTH (1)
    ) u_done_dly (
        .clk   (clk),
        .reset (reset),
        .d     (done),
        .q     (ntt_finished)
    );

endmodule

`default_nettype wire

// ==== hw/ntt_addr_gen.sv ====
// NTT address generator top: sequencer, address stage and alignment
// stage in a row; start is a one-cycle pulse, ntt_finished marks the end
`default_nettype none
`timescale 1ns/1ps

module ntt_addr_gen (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    output ntt_addr_pkg::bank_addr_t         raddr0,
    output ntt_addr_pkg::bank_addr_t         waddr0,
    output ntt_addr_pkg::bank_addr_t         waddr1,
    output logic                             wen0,
    output logic                             wen1,
    output logic                             brsel0,
    output logic                             brsel1,
    output logic                             brselen0,
    output logic                             brselen1,
    output logic                             ntt_finished,
    output logic [ntt_addr_pkg::STAGE_W-1:0] stage_count
);

    // sequencer to address stage
    logic                             run;
    logic                             stage_end;
    logic                             done;
    logic [ntt_addr_pkg::LOOP_W-1:0]  loop_idx;
    logic [ntt_addr_pkg::STAGE_W-1:0] stage_idx;
    // address stage to alignment
    ntt_addr_pkg::bank_addr_t         rd_addr;
    ntt_addr_pkg::bank_addr_t         wr_addr_even;
    ntt_addr_pkg::bank_addr_t         wr_addr_odd;
    logic                             wen;
    logic                             brsel;
    logic                             brselen;
    logic [ntt_addr_pkg::STAGE_W-1:0] stage_q;

    ntt_sequencer u_seq (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .run       (run),
        .stage_end (stage_end),
        .done      (done),
        .loop_idx  (loop_idx),
        .stage_idx (stage_idx)
    );

    ntt_addr_calc u_calc (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .run          (run),
        .stage_end    (stage_end),
        .loop_idx     (loop_idx),
        .stage_idx    (stage_idx),
        .rd_addr      (rd_addr),
        .wr_addr_even (wr_addr_even),
        .wr_addr_odd  (wr_addr_odd),
        .wen          (wen),
        .brsel        (brsel),
        .brselen      (brselen),
        .stage_q      (stage_q)
    );

    ntt_write_align u_align (
        .clk          (clk),
        .reset        (reset),
        .rd_addr      (rd_addr),
        .wr_addr_even (wr_addr_even),
        .wr_addr_odd  (wr_addr_odd),
        .wen          (wen),
        .brsel        (brsel),
        .brselen      (brselen),
        .done         (done),
        .stage_q      (stage_q),
        .raddr0       (raddr0),
        .waddr0       (waddr0),
        .waddr1       (waddr1),
        .wen0         (wen0),
        .wen1         (wen1),
        .brsel0       (brsel0),
        .brsel1       (brsel1),
        .brselen0     (brselen0),
        .brselen1     (brselen1),
        .ntt_finished (ntt_finished),
        .stage_count  (stage_count)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_ntt_addr_model.svh ====
// reference model of the NTT address pattern: expected read and write
// addresses for one stage and loop index, included inside the testbench
`ifndef TB_NTT_ADDR_MODEL_SVH
`define TB_NTT_ADDR_MODEL_SVH

// partner distance in a split stage, 16 rows in stage 0 and halving after
function automatic int row_span(input int stage);
    return 1 << (ntt_addr_pkg::SPLIT_STAGES - 1 - stage);
endfunction

// lower row of the butterfly pair issued at this loop index
function automatic int pair_row(input int stage, input int loop);
    int span;
    span = row_span(stage);
    return loop / 2 + (loop / (2 * span)) * span;
endfunction

function automatic bit is_split(input int stage);
    return stage < ntt_addr_pkg::SPLIT_STAGES;
endfunction

// write half starts at 01 and ping-pongs, the last stage lands in 10
function automatic int write_bank(input int stage);
    int bank;
    bank = 1;
    for (int s = 0; s < stage; s++) begin
        if (s == ntt_addr_pkg::STAGES - 2) begin
            bank = 2;
        end else begin
            bank = bank ^ 1;    // flip at every stage end
        end
    end
    return bank;
endfunction

function automatic ntt_addr_pkg::bank_addr_t make_addr(input int bank, input int row);
    ntt_addr_pkg::bank_addr_t a;
    a.f.bank = ntt_addr_pkg::BANK_W'(bank);
    a.f.row  = ntt_addr_pkg::ROW_W'(row);
    return a;
endfunction

// read row alternates between the two pair rows, read half flips per stage
function automatic ntt_addr_pkg::bank_addr_t expected_read(input int stage, input int loop);
    int row;
    row = loop;                                     // late stages pass the loop index
    if (is_split(stage)) begin
        row = pair_row(stage, loop) + (loop % 2) * row_span(stage);
    end
    return make_addr(stage % 2, row);
endfunction

// even side writes the lower pair row, odd side the upper one
function automatic ntt_addr_pkg::bank_addr_t expected_write(input int stage, input int loop,
                                                            input bit odd);
    int row;
    row = loop;
    if (is_split(stage)) begin
        row = pair_row(stage, loop) + (odd ? row_span(stage) : 0);
    end
    return make_addr(write_bank(stage), row);
endfunction

`endif

// ==== testbench/tb_ntt_addr_gen.sv ====
// testbench for the NTT address generator: three full transforms with
// random idle gaps and one stray start pulse, checked every cycle by
// assertions against a timing reference and the address model
`default_nettype none
`timescale 1ns/1ps

module tb_ntt_addr_gen;

    localparam int STAGE_LEN = ntt_addr_pkg::LOOPS + ntt_addr_pkg::WAIT_CYCLES;
    localparam int RUN_LEN   = ntt_addr_pkg::STAGES * STAGE_LEN;
    localparam int RD_LAT    = 2;                                  // run cycle to raddr0
    localparam int WR_LAT    = ntt_addr_pkg::BUTTERFLY_DELAY + 1;  // run cycle to wen0
    localparam int FIN_LAT   = 1 + ntt_addr_pkg::DONE_DELAY;       // last drain cycle to finish
    localparam int RUNS      = 3;

    logic                             clk;
    logic                             reset;
    logic                             start;
    ntt_addr_pkg::bank_addr_t         raddr0;
    ntt_addr_pkg::bank_addr_t         waddr0;
    ntt_addr_pkg::bank_addr_t         waddr1;
    logic                             wen0;
    logic                             wen1;
    logic                             brsel0;
    logic                             brsel1;
    logic                             brselen0;
    logic                             brselen1;
    logic                             ntt_finished;
    logic [ntt_addr_pkg::STAGE_W-1:0] stage_count;

    int                               ref_t = -1;      // cycle within the transform, -1 idle
    logic                             armed = 1'b0;    // first clock edge seen
    logic                             started = 1'b0;
    logic [1:0]                       rd_pipe = '0;    // run delayed to the read output
    logic [ntt_addr_pkg::LOOPS-1:0]   rows_seen = '0;
    logic                             exp_run;
    logic                             exp_last;
    logic [ntt_addr_pkg::STAGE_W-1:0] exp_stage;
    logic [ntt_addr_pkg::LOOP_W-1:0]  exp_loop;
    ntt_addr_pkg::bank_addr_t         exp_rd;
    ntt_addr_pkg::bank_addr_t         exp_we;
    ntt_addr_pkg::bank_addr_t         exp_wo;
    int                               errors = 0;
    int                               tests = 0;

    `include "tb_ntt_addr_model.svh"

    ntt_addr_gen u_dut (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .raddr0       (raddr0),
        .waddr0       (waddr0),
        .waddr1       (waddr1),
        .wen0         (wen0),
        .wen1         (wen1),
        .brsel0       (brsel0),
        .brsel1       (brsel1),
        .brselen0     (brselen0),
        .brselen1     (brselen1),
        .ntt_finished (ntt_finished),
        .stage_count  (stage_count)
    );

    always #4 clk = ~clk;    // 8 ns period

    // ------------------------------------------------------------------------
    // timing reference: a start sampled while idle opens STAGES stages
    always @(posedge clk) begin
        armed   <= 1'b1;
        rd_pipe <= {rd_pipe[0], exp_run};
        if (reset) begin
            ref_t <= -1;
        end else if (ref_t >= 0 && ref_t < RUN_LEN - 1) begin
            ref_t <= ref_t + 1;
        end else if (ref_t < 0 && start) begin
            ref_t   <= 0;
            started <= 1'b1;
        end else begin
            ref_t <= -1;    // transform over, stray starts are ignored
        end
        if (rd_pipe[1]) begin
            rows_seen <= rows_seen | (ntt_addr_pkg::LOOPS'(1) << raddr0.f.row);
        end else begin
            rows_seen <= '0;
        end
    end

    always_comb begin
        exp_run   = (ref_t >= 0) && ((ref_t % STAGE_LEN) < ntt_addr_pkg::LOOPS);
        exp_last  = (ref_t == RUN_LEN - 1);
        exp_stage = (ref_t >= 0) ? ntt_addr_pkg::STAGE_W'(ref_t / STAGE_LEN) : '0;
        exp_loop  = exp_run ? ntt_addr_pkg::LOOP_W'(ref_t % STAGE_LEN) : '0;
        exp_rd    = expected_read(int'(exp_stage), int'(exp_loop));
        exp_we    = expected_write(int'(exp_stage), int'(exp_loop), 1'b0);
        exp_wo    = expected_write(int'(exp_stage), int'(exp_loop), 1'b1);
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    // ------------------------------------------------------------------------
    // checks
    a_reset_state: assert property (@(posedge clk) (armed && !started) |->
        ({raddr0, waddr0, waddr1, stage_count} == '0 &&
         {wen0, wen1, brsel0, brsel1, brselen0, brselen1, ntt_finished} == '0))
        else report_mismatch("outputs not all zero before the first start");
    a_finished: assert property (@(posedge clk) disable iff (reset)
        ntt_finished == $past(exp_last, FIN_LAT))
        else report_mismatch($sformatf("ntt_finished = %b off schedule", $sampled(ntt_finished)));
    a_read_addr: assert property (@(posedge clk) disable iff (reset)
        $past(exp_run, RD_LAT) |-> raddr0 == $past(exp_rd, RD_LAT))
        else report_mismatch($sformatf("raddr0 = %h, model differs", $sampled(raddr0)));
    a_read_rows: assert property (@(posedge clk) disable iff (reset)
        (rd_pipe[1] && !rd_pipe[0]) |->
        ((rows_seen | (ntt_addr_pkg::LOOPS'(1) << raddr0.f.row)) == '1))
        else report_mismatch("a stage did not read every row exactly once");
    a_wen0: assert property (@(posedge clk) disable iff (reset)
        wen0 == $past(exp_run, WR_LAT))
        else report_mismatch($sformatf("wen0 = %b off schedule", $sampled(wen0)));
    a_odd_lag: assert property (@(posedge clk) disable iff (reset)
        wen1 == $past(exp_run, WR_LAT + 1) && brsel1 == $past(exp_loop[0], WR_LAT + 1))
        else report_mismatch($sformatf("wen1 = %b brsel1 = %b off schedule",
                                       $sampled(wen1), $sampled(brsel1)));
    a_brsel: assert property (@(posedge clk) disable iff (reset)
        brsel0 == $past(exp_loop[0], WR_LAT) && brselen0 == $past(exp_run, WR_LAT) &&
        brselen1 == $past(exp_run, WR_LAT + 1))
        else report_mismatch($sformatf("brsel0 = %b brselen0 = %b brselen1 = %b wrong",
                                       $sampled(brsel0), $sampled(brselen0),
                                       $sampled(brselen1)));
    a_waddr0: assert property (@(posedge clk) disable iff (reset)
        wen0 |-> waddr0 == $past(exp_we, WR_LAT))
        else report_mismatch($sformatf("waddr0 = %h, model differs", $sampled(waddr0)));
    a_waddr1: assert property (@(posedge clk) disable iff (reset)
        wen1 |-> waddr1 == $past(exp_wo, WR_LAT + 1))
        else report_mismatch($sformatf("waddr1 = %h, model differs", $sampled(waddr1)));
    a_stage_count: assert property (@(posedge clk) disable iff (reset)
        wen1 |-> stage_count == $past(exp_stage, WR_LAT + 1))
        else report_mismatch($sformatf("stage_count = %0d wrong", $sampled(stage_count)));

    // ------------------------------------------------------------------------
    // stimulus
    task automatic pulse_start();
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    // waits for ntt_finished or for the first write strobe
    task automatic wait_for_output(input bit finish_sig, input int limit);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(finish_sig ? ntt_finished : wen0) && n < limit);
        if (!(finish_sig ? ntt_finished : wen0)) begin
            $display("timeout: %s never rose within %0d cycles",
                     finish_sig ? "ntt_finished" : "wen0", limit);
            $display("ERRORS FOUND");
            $finish;
        end
    endtask

    initial begin
        int err_mark;
        clk   = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        void'($urandom(32'hdfb2_6ce8));
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        idle_cycles(5);
        tests++;
        $display("test reset state: %0d errors", errors);
        for (int r = 0; r < RUNS; r++) begin
            err_mark = errors;
            idle_cycles(1 + int'($urandom % 20));    // random idle gap
            pulse_start();
            if (r == 1) begin
                wait_for_output(1'b0, 4 * STAGE_LEN);
                idle_cycles(1 + int'($urandom % 150));
                pulse_start();                       // mid-run, must be ignored
            end
            wait_for_output(1'b1, RUN_LEN + 4 * STAGE_LEN);
            idle_cycles(WR_LAT + 2);
            tests++;
            $display("test run %0d: %0d errors", r, errors - err_mark);
        end
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+testbench
hw/ntt_addr_pkg.sv
hw/delay_line.sv
hw/ntt_sequencer.sv
hw/ntt_addr_calc.sv
hw/ntt_write_align.sv
hw/ntt_addr_gen.sv
testbench/tb_ntt_addr_gen.sv

// ==== Makefile ====
# Verilator build and run of the NTT address generator testbench

VERILATOR ?= verilator
TOP       ?= tb_ntt_addr_gen
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

# the run passes only if the pass message shows up in the output
run: build
	@out=$$($(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
